//--- Bender.yml
package:
  name: conv_1x1

sources:
  # Packages first
  - common/conv_data_pkg.sv
  - common/conv_ctrl_pkg.sv
  # Design
  - conv_1x1/cnn_fifo_delay.sv
  - conv_1x1/conv_1x1_buffer_weights.sv
  - conv_1x1/conv_1x1_ctrl.sv
  - conv_1x1/conv_1x1_mac.sv
  - conv_1x1/conv_1x1_top.sv
  # Verification
  - target: test
    files:
      - dv/conv_1x1_chk.sv
      - dv/conv_1x1_tb.sv

//--- common/conv_ctrl_pkg.sv
// Stream tagging and controller encodings
package conv_ctrl_pkg;

	// Tag carried with every input word
	typedef enum logic {
		KIND_WEIGHT = 1'b0,
		KIND_PIXEL  = 1'b1
	} word_kind_e;

	// Controller states
	typedef enum logic [1:0] {
		// Nothing stored yet
		ST_EMPTY  = 2'd0,
		// Weight set partly collected
		ST_LOAD   = 2'd1,
		// Last weight on its way into the FIFO
		ST_SETTLE = 2'd2,
		// Full set stored, pixels accepted
		ST_READY  = 2'd3
	} ctrl_state_e;

endpackage

//--- common/conv_data_pkg.sv
// Numeric format of the convolution datapath
package conv_data_pkg;

	////////////////////////////////////////////////////////////
	// Fixed-point format
	////////////////////////////////////////////////////////////

	// Fraction bits of both weights and pixels
	// Q(DATA_WIDTH-8).8 times Q.8 gives a .16 product
	localparam int FRAC_BITS = 8;

	////////////////////////////////////////////////////////////
	// Accumulator sizing
	////////////////////////////////////////////////////////////

	// Extra bits above 2*DATA_WIDTH
	// Covers a sum of up to 16 full-scale products
	localparam int ACC_GUARD = 4;

endpackage

//--- conv_1x1/cnn_fifo_delay.sv
`timescale 1ns/1ps

module cnn_fifo_delay #(
	parameter int DATA_WIDTH = 16,
	parameter int DATA_DEPTH = 4
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  flush,
	input  logic                  write,
	input  logic                  read,
	input  logic [DATA_WIDTH-1:0] data_in,
	output logic [DATA_WIDTH-1:0] data_out,
	output logic                  full,
	output logic                  empty
);

	// Pointer and occupancy widths
	localparam int PTR_W = (DATA_DEPTH > 1) ? $clog2(DATA_DEPTH) : 1;
	localparam int CNT_W = $clog2(DATA_DEPTH + 1);

	logic [DATA_WIDTH-1:0] mem [DATA_DEPTH];
	logic [PTR_W-1:0]      wr_ptr;
	logic [PTR_W-1:0]      rd_ptr;
	logic [CNT_W-1:0]      count;
	logic                  do_read;
	logic                  do_write;

	// Wrap at DATA_DEPTH, not at a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DATA_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full  = (count == CNT_W'(DATA_DEPTH));
	assign empty = (count == '0);

	// Flush beats any access in the same cycle
	assign do_read  = read && !flush && !empty;
	// A pop in the same cycle frees a slot for the write
	assign do_write = write && !flush && (!full || do_read);

	////////////////////////////////////////////////////////////
	// Pointers and count
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_read) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_write, do_read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage and registered read port
	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr] <= data_in;
		end
		if (do_read) begin
			data_out <= mem[rd_ptr];
		end
	end

endmodule

//--- conv_1x1/conv_1x1_buffer_weights.sv
`timescale 1ns/1ps

module conv_1x1_buffer_weights #(
	parameter int DATA_WIDTH = 16,
	parameter int CHANNELS   = 4
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  valid_in,
	input  logic [DATA_WIDTH-1:0] in,
	input  logic                  flush,
	input  logic                  load_weights,
	output logic [DATA_WIDTH-1:0] out_buffer_weight,
	output logic                  valid_out
);

	// Input stage
	logic [DATA_WIDTH-1:0] wt_q;
	logic                  wt_vq;

	// FIFO side
	logic [DATA_WIDTH-1:0] fifo_din;
	logic                  fifo_write;
	logic                  fifo_full;
	logic                  fifo_empty;

	////////////////////////////////////////////////////////////
	// Weight input register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			wt_vq <= 1'b0;
		end else begin
			wt_vq <= valid_in;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_in) begin
			wt_q <= in;
		end
	end

	// Popped weight goes back to the tail once used
	// New weights and returns never coincide
	assign fifo_write = wt_vq || valid_out;
	assign fifo_din   = wt_vq ? wt_q : out_buffer_weight;

	// One slot per channel
	cnn_fifo_delay #(
		.DATA_WIDTH(DATA_WIDTH),
		.DATA_DEPTH(CHANNELS)
	) u_fifo (
		.clk     (clk),
		.reset   (reset),
		.flush   (flush),
		.write   (fifo_write),
		.read    (load_weights),
		.data_in (fifo_din),
		.data_out(out_buffer_weight),
		.full    (fifo_full),
		.empty   (fifo_empty)
	);

	// Read data valid one cycle after the pop
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else begin
			valid_out <= load_weights;
		end
	end

endmodule

//--- conv_1x1/conv_1x1_ctrl.sv
`timescale 1ns/1ps

module conv_1x1_ctrl import conv_ctrl_pkg::*; #(
	parameter int CHANNELS = 4
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       in_valid,
	input  word_kind_e in_kind,
	output logic       wt_write,
	output logic       flush,
	output logic       load_weights,
	output logic       pix_accept,
	output logic       channel_last
);

	localparam int CNT_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;

	ctrl_state_e      state;
	logic [CNT_W-1:0] wt_cnt;
	logic [CNT_W-1:0] wt_base;
	logic [CNT_W-1:0] ch_cnt;
	logic             weight_word;
	logic             pixel_word;
	logic             restart;

	////////////////////////////////////////////////////////////
	// Word decode
	////////////////////////////////////////////////////////////
	assign weight_word = in_valid && (in_kind == KIND_WEIGHT);
	assign pixel_word  = in_valid && (in_kind == KIND_PIXEL);

	// Weight after a complete set starts over
	// SETTLE too, so a set is never mixed with the old one
	assign restart = weight_word && ((state == ST_SETTLE) || (state == ST_READY));
	assign flush   = restart;

	// Every weight word is stored, the restarting one included
	assign wt_write = weight_word;

	// Pixels only once the whole set sits in the FIFO
	assign pix_accept   = pixel_word && (state == ST_READY);
	assign load_weights = pix_accept;
	assign channel_last = pix_accept && (ch_cnt == CNT_W'(CHANNELS - 1));

	// Restarting word counts as the first one
	assign wt_base = restart ? '0 : wt_cnt;

	////////////////////////////////////////////////////////////
	// State and weight counter
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state  <= ST_EMPTY;
			wt_cnt <= '0;
		end else if (weight_word) begin
			if (wt_base == CNT_W'(CHANNELS - 1)) begin
				state  <= ST_SETTLE;
				wt_cnt <= '0;
			end else begin
				state  <= ST_LOAD;
				wt_cnt <= wt_base + 1'b1;
			end
		end else if (state == ST_SETTLE) begin
			state <= ST_READY;
		end
	end

	// Channel position within the current pixel
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			ch_cnt <= '0;
		end else if (pix_accept) begin
			ch_cnt <= channel_last ? '0 : ch_cnt + 1'b1;
		end
	end

endmodule

//--- conv_1x1/conv_1x1_mac.sv
`timescale 1ns/1ps

module conv_1x1_mac import conv_data_pkg::*; #(
	parameter int DATA_WIDTH = 16,
	parameter int CHANNELS   = 4
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  pix_accept,
	input  logic                  channel_last,
	input  logic [DATA_WIDTH-1:0] pixel,
	input  logic [DATA_WIDTH-1:0] weight,
	input  logic                  weight_valid,
	input  logic                  relu_en,
	output logic                  out_valid,
	output logic [DATA_WIDTH-1:0] out_data
);

	// Guard grows if CHANNELS needs more than ACC_GUARD
	localparam int GUARD = ($clog2(CHANNELS) > ACC_GUARD) ? $clog2(CHANNELS) : ACC_GUARD;
	localparam int ACC_W = 2 * DATA_WIDTH + GUARD;

	// Signed DATA_WIDTH range at accumulator width
	localparam logic signed [ACC_W-1:0] SAT_MAX =
		{{(ACC_W - DATA_WIDTH + 1){1'b0}}, {(DATA_WIDTH - 1){1'b1}}};
	localparam logic signed [ACC_W-1:0] SAT_MIN =
		{{(ACC_W - DATA_WIDTH + 1){1'b1}}, {(DATA_WIDTH - 1){1'b0}}};

	logic signed [DATA_WIDTH-1:0]   pix_q;
	logic                           last_q;
	logic signed [2*DATA_WIDTH-1:0] product;
	logic signed [ACC_W-1:0]        acc;
	logic signed [ACC_W-1:0]        acc_next;
	logic signed [ACC_W-1:0]        sum_q;
	logic                           sum_valid;
	logic signed [ACC_W-1:0]        shifted;
	logic signed [ACC_W-1:0]        clipped;

	////////////////////////////////////////////////////////////
	// Stage 1: align pixel with the popped weight
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (pix_accept) begin
			pix_q <= pixel;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			last_q <= 1'b0;
		end else begin
			last_q <= pix_accept && channel_last;
		end
	end

	assign product  = pix_q * $signed(weight);
	assign acc_next = acc + product;

	////////////////////////////////////////////////////////////
	// Stage 2: accumulate, hand off the finished sum
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			acc       <= '0;
			sum_valid <= 1'b0;
		end else begin
			sum_valid <= weight_valid && last_q;
			if (weight_valid) begin
				// Next pixel starts from zero
				acc <= last_q ? '0 : acc_next;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (weight_valid && last_q) begin
			sum_q <= acc_next;
		end
	end

	// Drop fraction bits, keep sign
	assign shifted = sum_q >>> FRAC_BITS;

	always_comb begin
		if (shifted > SAT_MAX) begin
			clipped = SAT_MAX;
		end else if (shifted < SAT_MIN) begin
			clipped = SAT_MIN;
		end else begin
			clipped = shifted;
		end
		// ReLU on the saturated value
		if (relu_en && clipped[ACC_W-1]) begin
			clipped = '0;
		end
	end

	////////////////////////////////////////////////////////////
	// Stage 3: output register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= sum_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (sum_valid) begin
			out_data <= clipped[DATA_WIDTH-1:0];
		end
	end

endmodule

//--- conv_1x1/conv_1x1_top.sv
`timescale 1ns/1ps

module conv_1x1_top import conv_ctrl_pkg::*; #(
	parameter int DATA_WIDTH = 16,
	parameter int CHANNELS   = 4
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  in_valid,
	input  word_kind_e            in_kind,
	input  logic [DATA_WIDTH-1:0] in_data,
	input  logic                  relu_en,
	output logic                  out_valid,
	output logic [DATA_WIDTH-1:0] out_data
);

	// Controller strobes
	logic                  wt_write;
	logic                  flush;
	logic                  load_weights;
	logic                  pix_accept;
	logic                  channel_last;

	// Weight path into the MAC
	logic [DATA_WIDTH-1:0] weight;
	logic                  weight_valid;

	conv_1x1_ctrl #(
		.CHANNELS(CHANNELS)
	) u_ctrl (
		.clk         (clk),
		.reset       (reset),
		.in_valid    (in_valid),
		.in_kind     (in_kind),
		.wt_write    (wt_write),
		.flush       (flush),
		.load_weights(load_weights),
		.pix_accept  (pix_accept),
		.channel_last(channel_last)
	);

	// Weights come straight from the stream
	conv_1x1_buffer_weights #(
		.DATA_WIDTH(DATA_WIDTH),
		.CHANNELS  (CHANNELS)
	) u_buffer_weights (
		.clk              (clk),
		.reset            (reset),
		.valid_in         (wt_write),
		.in               (in_data),
		.flush            (flush),
		.load_weights     (load_weights),
		.out_buffer_weight(weight),
		.valid_out        (weight_valid)
	);

	conv_1x1_mac #(
		.DATA_WIDTH(DATA_WIDTH),
		.CHANNELS  (CHANNELS)
	) u_mac (
		.clk         (clk),
		.reset       (reset),
		.pix_accept  (pix_accept),
		.channel_last(channel_last),
		.pixel       (in_data),
		.weight      (weight),
		.weight_valid(weight_valid),
		.relu_en     (relu_en),
		.out_valid   (out_valid),
		.out_data    (out_data)
	);

endmodule

//--- dv/conv_1x1_chk.sv
`timescale 1ns/1ps

module conv_1x1_chk #(
	parameter int DATA_WIDTH = 16
) (
	input logic                  clk,
	input logic                  reset,
	input logic                  relu_en,
	input logic                  out_valid,
	input logic [DATA_WIDTH-1:0] out_data,
	input logic                  load_weights,
	input logic                  fifo_write,
	input logic                  fifo_full,
	input logic                  fifo_empty
);

	////////////////////////////////////////////////////////////
	// Reset behavior
	////////////////////////////////////////////////////////////
	quiet_out_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
		else $error("out_valid high in the cycle after reset");

	quiet_load_after_reset: assert property (@(posedge clk) reset |=> !load_weights)
		else $error("load_weights high in the cycle after reset");

	// Pop only with weights stored
	no_pop_when_empty: assert property (@(posedge clk) disable iff (reset)
		load_weights |-> !fifo_empty)
		else $error("load_weights while the weight FIFO is empty");

	// Loading and rotation never overrun the FIFO
	no_write_when_full: assert property (@(posedge clk) disable iff (reset)
		fifo_write |-> !fifo_full)
		else $error("Weight FIFO written while full");

	// ReLU seen at the edge that registered out_data
	relu_non_negative: assert property (@(posedge clk) disable iff (reset)
		(out_valid && $past(relu_en)) |-> !out_data[DATA_WIDTH-1])
		else $error("Negative out_data with ReLU enabled");

endmodule

bind conv_1x1_top conv_1x1_chk #(
	.DATA_WIDTH(DATA_WIDTH)
) u_chk (
	.clk         (clk),
	.reset       (reset),
	.relu_en     (relu_en),
	.out_valid   (out_valid),
	.out_data    (out_data),
	.load_weights(load_weights),
	.fifo_write  (u_buffer_weights.fifo_write),
	.fifo_full   (u_buffer_weights.fifo_full),
	.fifo_empty  (u_buffer_weights.fifo_empty)
);

//--- dv/conv_1x1_tb.sv
`timescale 1ns/1ps

module conv_1x1_tb import conv_ctrl_pkg::*, conv_data_pkg::*; ();

	localparam int DW = 16;
	localparam int CH = 4;
	localparam int MAX_IDLE = 3;
	// Signed output range
	localparam longint SAT_HI = (longint'(1) <<< (DW - 1)) - 1;
	localparam longint SAT_LO = -(longint'(1) <<< (DW - 1));

	logic          clk = 1'b0;
	logic          reset;
	logic          in_valid;
	word_kind_e    in_kind;
	logic [DW-1:0] in_data;
	logic          relu_en;
	logic          out_valid;
	logic [DW-1:0] out_data;

	int seed = 32'h4e3;

	// Stimulus table, last flag marks a word that completes a pixel
	word_kind_e    tbl_kind[$];
	logic [DW-1:0] tbl_data[$];
	bit            tbl_relu[$];
	int            tbl_idle[$];
	bit            tbl_last[$];

	// Reference model
	ctrl_state_e   m_state;
	int            m_wcnt;
	int            m_ch;
	longint        m_load_w[CH];
	longint        m_use_w[CH];
	longint        m_acc;
	bit            s1_v;
	bit            s2_v;
	longint        s1_sum;
	longint        s2_sum;
	logic [DW-1:0] exp_q[$];
	logic [DW-1:0] exp_v;

	int n_mismatch = 0;
	int n_unexp = 0;
	int n_missing = 0;
	int n_table = 0;
	int wd_cycles;
	bit tbl_ready = 1'b0;
	bit done;
	int i;

	conv_1x1_top #(
		.DATA_WIDTH(DW),
		.CHANNELS  (CH)
	) UUT (
		.clk      (clk),
		.reset    (reset),
		.in_valid (in_valid),
		.in_kind  (in_kind),
		.in_data  (in_data),
		.relu_en  (relu_en),
		.out_valid(out_valid),
		.out_data (out_data)
	);

	initial begin
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Table building
	////////////////////////////////////////////////////////////
	task automatic add_row(input word_kind_e kind, input logic [DW-1:0] data,
			input bit relu, input int idle, input bit last);
		tbl_kind.push_back(kind);
		tbl_data.push_back(data);
		tbl_relu.push_back(relu);
		tbl_idle.push_back(idle);
		tbl_last.push_back(last);
	endtask

	task automatic add_pixel(input logic [DW-1:0] c0, c1, c2, c3, input bit relu, input int gap);
		add_row(KIND_PIXEL, c0, relu, 0, 0);
		add_row(KIND_PIXEL, c1, relu, 0, 0);
		add_row(KIND_PIXEL, c2, relu, 0, 0);
		add_row(KIND_PIXEL, c3, relu, gap, 1);
	endtask

	// Gap after the last weight, 0 lands the next word in SETTLE
	task automatic add_weights(input logic [DW-1:0] w0, w1, w2, w3, input int gap);
		add_row(KIND_WEIGHT, w0, 0, 0, 0);
		add_row(KIND_WEIGHT, w1, 0, 0, 0);
		add_row(KIND_WEIGHT, w2, 0, 0, 0);
		add_row(KIND_WEIGHT, w3, 0, gap, 0);
	endtask

	task automatic add_random_pixels(input int n, input bit relu, input int max_gap);
		logic [DW-1:0] c[CH];
		int gap;
		for (int p = 0; p < n; p++) begin
			for (int j = 0; j < CH; j++) begin
				c[j] = $random(seed);
			end
			gap = $unsigned($random(seed)) % (max_gap + 1);
			add_pixel(c[0], c[1], c[2], c[3], relu, gap);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Reference model, one call per rising edge
	////////////////////////////////////////////////////////////
	function automatic logic [DW-1:0] finish_sum(input longint sum, input bit relu);
		longint v;
		v = sum >>> FRAC_BITS;
		if (v > SAT_HI) begin
			v = SAT_HI;
		end else if (v < SAT_LO) begin
			v = SAT_LO;
		end
		if (relu && v < 0) begin
			v = 0;
		end
		return v[DW-1:0];
	endfunction

	task automatic model_step(input bit valid, input word_kind_e kind, input logic [DW-1:0] data,
			input bit relu, output bit last);
		longint val;
		val = $signed(data);
		last = 1'b0;
		// Two-cycle output pipeline, ReLU taken at the output edge
		if (s2_v) begin
			exp_q.push_back(finish_sum(s2_sum, relu));
		end
		s2_v = s1_v;
		s2_sum = s1_sum;
		s1_v = 1'b0;
		if (valid && kind == KIND_WEIGHT) begin
			// New set once the old one is complete
			if (m_state == ST_SETTLE || m_state == ST_READY) begin
				m_wcnt = 0;
				m_ch = 0;
				m_acc = 0;
			end
			m_load_w[m_wcnt] = val;
			if (m_wcnt == CH - 1) begin
				m_state = ST_SETTLE;
				m_wcnt = 0;
				m_use_w = m_load_w;
			end else begin
				m_state = ST_LOAD;
				m_wcnt++;
			end
		end else begin
			// Pixels outside READY vanish
			if (valid && m_state == ST_READY) begin
				m_acc += val * m_use_w[m_ch];
				if (m_ch == CH - 1) begin
					s1_v = 1'b1;
					s1_sum = m_acc;
					m_acc = 0;
					m_ch = 0;
					last = 1'b1;
				end else begin
					m_ch++;
				end
			end
			if (m_state == ST_SETTLE) begin
				m_state = ST_READY;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Output compare
	////////////////////////////////////////////////////////////
	always @(negedge clk) begin
		if (!reset && out_valid) begin
			assert (exp_q.size() > 0) else begin
				$display("Output at time %0t arrived with no result expected", $time);
				n_unexp++;
			end
			if (exp_q.size() > 0) begin
				exp_v = exp_q.pop_front();
				assert (out_data === exp_v) else begin
					$display("Fail at time %0t: out_data expected %h, actual %h",
						$time, exp_v, out_data);
					n_mismatch++;
				end
			end
		end
	end

	// Watchdog
	initial begin
		wait (tbl_ready);
		repeat (wd_cycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles, stimulus never finished", wd_cycles);
		$display("Testbench failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////
	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		in_kind = KIND_WEIGHT;
		in_data = '0;
		relu_en = 1'b0;
		m_state = ST_EMPTY;
		m_wcnt = 0;
		m_ch = 0;
		m_acc = 0;
		s1_v = 1'b0;
		s2_v = 1'b0;

		// No weights yet, both dropped
		add_row(KIND_PIXEL, 16'h0100, 0, 0, 0);
		add_row(KIND_PIXEL, 16'h0100, 0, 0, 0);
		// First set with a stray pixel while loading
		add_row(KIND_WEIGHT, 16'h0100, 0, 0, 0);
		add_row(KIND_WEIGHT, 16'h0080, 0, 0, 0);
		add_row(KIND_PIXEL, 16'h1234, 0, 0, 0);
		add_row(KIND_WEIGHT, 16'hff00, 0, 0, 0);
		add_row(KIND_WEIGHT, 16'h0200, 0, 0, 0);
		// Settle cycle word is dropped
		add_row(KIND_PIXEL, 16'h0100, 0, 0, 0);
		// 1.0 on all channels gives 2.5
		add_pixel(16'h0100, 16'h0100, 16'h0100, 16'h0100, 0, 0);
		// Long back-to-back run, weights must rotate
		add_random_pixels(12, 0, 0);
		add_random_pixels(6, 0, MAX_IDLE);
		// Negative result with and without ReLU
		add_pixel(16'h0000, 16'h0000, 16'h0400, 16'h0000, 1, 2);
		add_pixel(16'h0000, 16'h0000, 16'h0400, 16'h0000, 0, 2);
		add_random_pixels(6, 1, 2);
		// Restart while ready
		add_weights(16'h0040, 16'hfe00, 16'h0100, 16'h0300, 1);
		add_random_pixels(8, 0, 1);
		// Saturation at both limits
		add_weights(16'h7fff, 16'h7fff, 16'h7fff, 16'h7fff, 1);
		add_pixel(16'h7fff, 16'h7fff, 16'h7fff, 16'h7fff, 0, 2);
		add_pixel(16'h8000, 16'h8000, 16'h8000, 16'h8000, 0, 2);
		add_pixel(16'h8000, 16'h8000, 16'h8000, 16'h8000, 1, 2);
		add_weights(16'h8000, 16'h8000, 16'h8000, 16'h8000, 1);
		add_pixel(16'h8000, 16'h8000, 16'h8000, 16'h8000, 0, 2);

		wd_cycles = tbl_kind.size() * (MAX_IDLE + 10);
		tbl_ready = 1'b1;

		repeat (2) @(negedge clk);
		reset = 1'b0;

		for (i = 0; i < tbl_kind.size(); i++) begin
			@(negedge clk);
			in_valid = 1'b1;
			in_kind = tbl_kind[i];
			in_data = tbl_data[i];
			relu_en = tbl_relu[i];
			model_step(1'b1, in_kind, in_data, relu_en, done);
			assert (done == tbl_last[i]) else begin
				$display("Row %0d does not match the table on pixel completion", i);
				n_table++;
			end
			repeat (tbl_idle[i]) begin
				@(negedge clk);
				in_valid = 1'b0;
				model_step(1'b0, in_kind, in_data, relu_en, done);
			end
		end

		// Drain, output latency is 2 cycles
		repeat (4) begin
			@(negedge clk);
			in_valid = 1'b0;
			model_step(1'b0, in_kind, in_data, relu_en, done);
		end
		@(posedge clk);

		assert (exp_q.size() == 0) else begin
			$display("%0d expected outputs never appeared", exp_q.size());
			n_missing += exp_q.size();
		end

		$display("Errors: %0d (mismatch %0d, unexpected %0d, missing %0d, table %0d)",
			n_mismatch + n_unexp + n_missing + n_table, n_mismatch, n_unexp, n_missing, n_table);
		if (n_mismatch + n_unexp + n_missing + n_table == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- filelist.f
common/conv_data_pkg.sv
common/conv_ctrl_pkg.sv
conv_1x1/cnn_fifo_delay.sv
conv_1x1/conv_1x1_buffer_weights.sv
conv_1x1/conv_1x1_ctrl.sv
conv_1x1/conv_1x1_mac.sv
conv_1x1/conv_1x1_top.sv
dv/conv_1x1_chk.sv
dv/conv_1x1_tb.sv
